// File: filelist.f
hw/rover_pkg.sv
hw/drive_control.sv
hw/motor_pwm.sv
hw/echo_ranger.sv
hw/temp_display.sv
hw/rover_top.sv
test/rover_tb.sv

// File: hw/drive_control.sv
`timescale 1ns/1ps
`default_nettype none

module drive_control (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire rover_pkg::line_sensors_t line,
    input  wire logic                     oc_a,
    input  wire logic                     oc_b,
    input  wire logic                     clear_btn,
    input  wire logic                     obstacle,
    output rover_pkg::motor_dir_t         motor_dir,
    output logic                          motor_enable,
    output logic                          fault
);

    import rover_pkg::*;

    localparam logic [TURN_CNT_W-1:0] TURN_LAST = TURN_CNT_W'(TURN_CYCLES - 1);
    localparam logic [OC_CNT_W-1:0]   OC_LIMIT  = OC_CNT_W'(OC_HOLD_CYCLES);

    nav_state_t              state;
    logic [TURN_CNT_W-1:0]   turn_cnt;
    logic [OC_CNT_W-1:0]     oc_cnt;   // Saturates at OC_LIMIT
    motor_dir_t              follow_dir;
    logic                    crossroads;

    assign crossroads = !line.left && !line.center && !line.right;

    // Line following rules, shared by seek and follow
    always_comb begin
        if (!line.left && line.center && line.right) begin
            follow_dir = DIR_LEFT;
        end else if (line.left && line.center && !line.right) begin
            follow_dir = DIR_RIGHT;
        end else begin
            follow_dir = DIR_FWD;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= NAV_SEEK;
            turn_cnt  <= '0;
            motor_dir <= '0;
        end else begin
            case (state)
                NAV_SEEK: begin
                    if (crossroads) begin
                        state     <= NAV_TURN;
                        turn_cnt  <= '0;
                        motor_dir <= DIR_LEFT; // Spin starts right away
                    end else begin
                        motor_dir <= follow_dir;
                    end
                end
                NAV_TURN: begin
                    turn_cnt <= turn_cnt + 1'b1;
                    if (turn_cnt == TURN_LAST) begin
                        state     <= NAV_FOLLOW;
                        motor_dir <= follow_dir;
                    end else begin
                        motor_dir <= DIR_LEFT;
                    end
                end
                NAV_FOLLOW: motor_dir <= follow_dir; // Crossroads now just goes straight
                default: begin
                    state     <= NAV_SEEK;
                    motor_dir <= '0;
                end
            endcase
        end
    end

    // Overcurrent cycles accumulate until the button clears them
    always_ff @(posedge clk) begin
        if (rst || clear_btn) begin
            oc_cnt <= '0;
            fault  <= 1'b0;
        end else begin
            if ((oc_a || oc_b) && oc_cnt != OC_LIMIT) begin
                oc_cnt <= oc_cnt + 1'b1;
            end
            if (oc_cnt == OC_LIMIT) begin
                fault <= 1'b1;
            end
        end
    end

    assign motor_enable = !fault && !obstacle;

endmodule

`default_nettype wire

// File: hw/echo_ranger.sv
`timescale 1ns/1ps
`default_nettype none

module echo_ranger (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic echo,
    output logic      trigger,
    output logic      obstacle
);

    import rover_pkg::*;

    logic [ECHO_PERIOD_W-1:0] period_cnt;
    echo_width_t              pulse_cnt;  // Running echo width
    echo_width_t              echo_width; // Last complete echo
    logic                     echo_d;
    logic [FILTER_LEN-1:0]    near_hist;
    logic                     near;

    assign near = echo_width < echo_width_t'(NEAR_CYCLES);

    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;
            trigger    <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            trigger    <= period_cnt < ECHO_PERIOD_W'(TRIG_CYCLES);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_d     <= 1'b0;
            pulse_cnt  <= '0;
            echo_width <= '1; // Reads as far
        end else begin
            echo_d <= echo;
            if (echo_d && !echo) begin
                echo_width <= pulse_cnt;
                pulse_cnt  <= '0;
            end else if (echo && pulse_cnt != '1) begin
                pulse_cnt <= pulse_cnt + 1'b1; // Long echoes saturate
            end
        end
    end

    // One near reading anywhere in the history holds obstacle high
    always_ff @(posedge clk) begin
        if (rst) begin
            near_hist <= '0;
            obstacle  <= 1'b0;
        end else begin
            near_hist <= {near_hist[FILTER_LEN-2:0], near};
            obstacle  <= |near_hist;
        end
    end

endmodule

`default_nettype wire

// File: hw/motor_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module motor_pwm (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire rover_pkg::speed_t speed_a,
    input  wire rover_pkg::speed_t speed_b,
    input  wire logic              motor_enable,
    output logic                   pwm_a,
    output logic                   pwm_b
);

    import rover_pkg::*;

    pwm_cnt_t pwm_cnt; // Shared by both motors
    pwm_cnt_t duty_a;
    pwm_cnt_t duty_b;

    function automatic pwm_cnt_t speed_to_duty(input speed_t speed);
        case (speed)
            SPEED_LOW:  return DUTY_LOW;
            SPEED_MID:  return DUTY_MID;
            SPEED_FULL: return DUTY_FULL;
            default:    return '0;
        endcase
    endfunction

    assign duty_a = speed_to_duty(speed_a);
    assign duty_b = speed_to_duty(speed_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_cnt <= '0;
            pwm_a   <= 1'b0;
            pwm_b   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1; // Wraps every 256 cycles
            pwm_a   <= motor_enable && (pwm_cnt < duty_a);
            pwm_b   <= motor_enable && (pwm_cnt < duty_b);
        end
    end

endmodule

`default_nettype wire

// File: hw/rover_pkg.sv
`default_nettype none

package rover_pkg;

    typedef enum logic [1:0] {
        SPEED_OFF  = 2'd0,
        SPEED_LOW  = 2'd1,
        SPEED_MID  = 2'd2,
        SPEED_FULL = 2'd3
    } speed_t;

    typedef enum logic [1:0] {
        NAV_SEEK   = 2'd0, // Following, crossroads not yet seen
        NAV_TURN   = 2'd1, // Timed spin at the crossroads
        NAV_FOLLOW = 2'd2
    } nav_state_t;

    // Active low, 0 means the sensor is over the line
    typedef struct packed {
        logic left;
        logic center;
        logic right;
    } line_sensors_t;

    typedef struct packed {
        logic a_fwd;
        logic a_rev;
        logic b_fwd;
        logic b_rev;
    } motor_dir_t;

    localparam int PWM_W = 8;
    typedef logic [PWM_W-1:0] pwm_cnt_t;

    typedef logic [6:0] seg_t; // g down to a, active low
    typedef logic [3:0] digit_t;

    localparam pwm_cnt_t DUTY_LOW  = 8'd140; // About 55%
    localparam pwm_cnt_t DUTY_MID  = 8'd179; // About 70%
    localparam pwm_cnt_t DUTY_FULL = 8'd255;

    localparam motor_dir_t DIR_FWD   = 4'b1010;
    localparam motor_dir_t DIR_LEFT  = 4'b0110; // A reverse, B forward
    localparam motor_dir_t DIR_RIGHT = 4'b1001; // A forward, B reverse

    localparam int OC_HOLD_CYCLES = 64;
    localparam int OC_CNT_W       = 7;
    localparam int TURN_CYCLES    = 200;
    localparam int TURN_CNT_W     = 8;

    localparam int ECHO_PERIOD_W = 10;
    localparam int TRIG_CYCLES   = 16;
    localparam int NEAR_CYCLES   = 100;
    localparam int FILTER_LEN    = 8;
    typedef logic [ECHO_PERIOD_W-1:0] echo_width_t;

    localparam int ADC_W         = 12;
    localparam int SCAN_W        = 6;
    localparam int TEMP_OFFSET   = 1305;
    localparam int TEMP_TENS_DIV = 310;
    localparam int TEMP_ONES_DIV = 31;

    localparam seg_t SEG_0     = 7'b1000000;
    localparam seg_t SEG_1     = 7'b1111001;
    localparam seg_t SEG_2     = 7'b0100100;
    localparam seg_t SEG_3     = 7'b0110000;
    localparam seg_t SEG_4     = 7'b0011001;
    localparam seg_t SEG_5     = 7'b0010010;
    localparam seg_t SEG_6     = 7'b0000010;
    localparam seg_t SEG_7     = 7'b1111000;
    localparam seg_t SEG_8     = 7'b0000000;
    localparam seg_t SEG_9     = 7'b0010000;
    localparam seg_t SEG_DASH  = 7'b0111111;
    localparam seg_t SEG_C     = 7'b0100111;
    localparam seg_t SEG_BLANK = 7'b1111111;

    // Anode selects, active low, D3 is the leftmost digit
    localparam logic [3:0] AN_D3 = 4'b0111;
    localparam logic [3:0] AN_D2 = 4'b1011;
    localparam logic [3:0] AN_D1 = 4'b1101;
    localparam logic [3:0] AN_D0 = 4'b1110;

endpackage

`default_nettype wire

// File: hw/rover_top.sv
`timescale 1ns/1ps
`default_nettype none

module rover_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire rover_pkg::speed_t           speed_a,
    input  wire rover_pkg::speed_t           speed_b,
    input  wire logic                        oc_a,
    input  wire logic                        oc_b,
    input  wire logic                        clear_btn,
    input  wire rover_pkg::line_sensors_t    line,
    input  wire logic                        echo,
    input  wire logic [rover_pkg::ADC_W-1:0] adc_sample,
    input  wire logic                        adc_valid,
    output logic                             pwm_a,
    output logic                             pwm_b,
    output rover_pkg::motor_dir_t            motor_dir,
    output logic                             trigger,
    output logic                             obstacle,
    output logic                             fault,
    output rover_pkg::seg_t                  seg,
    output logic [3:0]                       an
);

    logic motor_enable; // Low on fault or obstacle

    drive_control drive_control_i (
        .clk          (clk),
        .rst          (rst),
        .line         (line),
        .oc_a         (oc_a),
        .oc_b         (oc_b),
        .clear_btn    (clear_btn),
        .obstacle     (obstacle),
        .motor_dir    (motor_dir),
        .motor_enable (motor_enable),
        .fault        (fault)
    );

    motor_pwm motor_pwm_i (
        .clk          (clk),
        .rst          (rst),
        .speed_a      (speed_a),
        .speed_b      (speed_b),
        .motor_enable (motor_enable),
        .pwm_a        (pwm_a),
        .pwm_b        (pwm_b)
    );

    echo_ranger echo_ranger_i (
        .clk      (clk),
        .rst      (rst),
        .echo     (echo),
        .trigger  (trigger),
        .obstacle (obstacle)
    );

    temp_display temp_display_i (
        .clk        (clk),
        .rst        (rst),
        .adc_sample (adc_sample),
        .adc_valid  (adc_valid),
        .fault      (fault),
        .seg        (seg),
        .an         (an)
    );

endmodule

`default_nettype wire

// File: hw/temp_display.sv
`timescale 1ns/1ps
`default_nettype none

module temp_display (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [rover_pkg::ADC_W-1:0] adc_sample,
    input  wire logic                        adc_valid,
    input  wire logic                        fault,
    output rover_pkg::seg_t                  seg,
    output logic [3:0]                       an
);

    import rover_pkg::*;

    logic [ADC_W-1:0]  above;    // Sample minus offset
    logic [ADC_W-1:0]  tens_q;
    logic [ADC_W-1:0]  ones_q;
    digit_t            tens;
    digit_t            ones;
    logic [SCAN_W-1:0] scan_cnt;
    seg_t              digit_seg;

    function automatic seg_t digit_to_seg(input digit_t d);
        case (d)
            4'd0:    return SEG_0;
            4'd1:    return SEG_1;
            4'd2:    return SEG_2;
            4'd3:    return SEG_3;
            4'd4:    return SEG_4;
            4'd5:    return SEG_5;
            4'd6:    return SEG_6;
            4'd7:    return SEG_7;
            4'd8:    return SEG_8;
            4'd9:    return SEG_9;
            default: return SEG_DASH;
        endcase
    endfunction

    assign above  = adc_sample - ADC_W'(TEMP_OFFSET);
    assign tens_q = above / ADC_W'(TEMP_TENS_DIV);
    assign ones_q = (above / ADC_W'(TEMP_ONES_DIV)) % ADC_W'(10);

    always_ff @(posedge clk) begin
        if (rst) begin
            tens <= '0;
            ones <= '0;
        end else if (adc_valid) begin
            if (adc_sample < ADC_W'(TEMP_OFFSET)) begin
                tens <= '0; // Below the scale floor
                ones <= '0;
            end else begin
                tens <= tens_q[3:0];
                ones <= ones_q[3:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // Top two scan bits pick the digit, leftmost first from 2'b11
    always_comb begin
        case (scan_cnt[SCAN_W-1 -: 2])
            2'b11: begin
                an        = AN_D3;
                digit_seg = digit_to_seg(tens);
            end
            2'b10: begin
                an        = AN_D2;
                digit_seg = digit_to_seg(ones);
            end
            2'b01: begin
                an        = AN_D1;
                digit_seg = SEG_C;
            end
            default: begin
                an        = AN_D0;
                digit_seg = SEG_BLANK;
            end
        endcase
    end

    assign seg = fault ? SEG_DASH : digit_seg;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the rover testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module rover_tb -o rover_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/rover_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TB PASSED$"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: test/rover_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rover_tb;

    import rover_pkg::*;

    localparam int MAX_CYCLES  = 20000;
    localparam int PWM_PERIOD  = 1 << PWM_W;
    localparam int SCAN_PERIOD = 1 << SCAN_W; // One pass over all four digits
    localparam int TRIG_PERIOD = 1 << ECHO_PERIOD_W;

    // Sensors are active low, a 0 sees the line
    localparam line_sensors_t LINE_NONE        = 3'b111;
    localparam line_sensors_t LINE_ALL         = 3'b000;
    localparam line_sensors_t LINE_LEFT        = 3'b011;
    localparam line_sensors_t LINE_RIGHT       = 3'b110;
    localparam line_sensors_t LINE_CENTER      = 3'b101;
    localparam line_sensors_t LINE_LEFT_CENTER = 3'b001;

    localparam motor_dir_t EXP_FWD        = 4'b1010; // a_fwd and b_fwd
    localparam motor_dir_t EXP_SPIN_LEFT  = 4'b0110; // a_rev and b_fwd
    localparam motor_dir_t EXP_SPIN_RIGHT = 4'b1001; // a_fwd and b_rev

    logic                 clk;
    logic                 rst;
    speed_t               speed_a;
    speed_t               speed_b;
    logic                 oc_a;
    logic                 oc_b;
    logic                 clear_btn;
    line_sensors_t        line;
    logic                 echo;
    logic [ADC_W-1:0]     adc_sample;
    logic                 adc_valid;
    logic                 pwm_a;
    logic                 pwm_b;
    motor_dir_t           motor_dir;
    logic                 trigger;
    logic                 obstacle;
    logic                 fault;
    seg_t                 seg;
    logic [3:0]           an;

    integer seed      = 32'h5cbd;
    int     cycle_cnt = 0;
    int     fail_cnt  = 0;

    rover_top rover_top_i (
        .clk        (clk),
        .rst        (rst),
        .speed_a    (speed_a),
        .speed_b    (speed_b),
        .oc_a       (oc_a),
        .oc_b       (oc_b),
        .clear_btn  (clear_btn),
        .line       (line),
        .echo       (echo),
        .adc_sample (adc_sample),
        .adc_valid  (adc_valid),
        .pwm_a      (pwm_a),
        .pwm_b      (pwm_b),
        .motor_dir  (motor_dir),
        .trigger    (trigger),
        .obstacle   (obstacle),
        .fault      (fault),
        .seg        (seg),
        .an         (an)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_failure(input string msg);
        fail_cnt++;
        $display("FAILED at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("%s: got %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_dir(input motor_dir_t actual, input motor_dir_t expected,
                             input string what);
        if (actual !== expected) begin
            report_failure($sformatf("%s: motor_dir %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_seg(input seg_t actual, input seg_t expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("%s: seg %b, expected %b", what, actual, expected));
        end
    endtask

    task automatic check_count(input int actual, input int expected, input int tol,
                               input string what);
        if (actual < expected - tol || actual > expected + tol) begin
            report_failure($sformatf("%s: got %0d, expected %0d +/- %0d",
                                     what, actual, expected, tol));
        end
    endtask

    // Edge plus 1 ns, so drives and samples never race the clock
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (5) next_cycle();
        rst = 1'b0;
    endtask

    task automatic count_pwm_high(output int hi_a, output int hi_b);
        hi_a = 0;
        hi_b = 0;
        repeat (PWM_PERIOD) begin
            next_cycle();
            if (pwm_a) hi_a++;
            if (pwm_b) hi_b++;
        end
    endtask

    task automatic steer_case(input line_sensors_t pattern, input motor_dir_t expected,
                              input string what);
        line = pattern;
        repeat (2) next_cycle();
        check_dir(motor_dir, expected, what);
    endtask

    task automatic send_echo(input int width);
        echo = 1'b1;
        repeat (width) next_cycle();
        echo = 1'b0;
    endtask

    // Latch takes one cycle, then the filter bound applies
    task automatic wait_obstacle(input logic level, input string what);
        int waited;
        waited = 0;
        while (obstacle !== level && waited < FILTER_LEN + 3) begin
            next_cycle();
            waited++;
        end
        check_bit(obstacle, level, what);
    endtask

    task automatic scan_display(input seg_t exp_tens, input seg_t exp_ones, input string what);
        logic [3:0] seen;
        seen = '0;
        repeat (SCAN_PERIOD) begin
            case (an)
                AN_D3:   check_seg(seg, exp_tens, {what, " tens digit"});
                AN_D2:   check_seg(seg, exp_ones, {what, " ones digit"});
                AN_D1:   check_seg(seg, SEG_C, {what, " unit digit"});
                AN_D0:   check_seg(seg, SEG_BLANK, {what, " blank digit"});
                default: report_failure($sformatf("%s: anode pattern %b", what, an));
            endcase
            seen = seen | ~an;
            next_cycle();
        end
        check_bit(&seen, 1'b1, {what, " all anodes scanned"});
    endtask

    task automatic reset_and_speed();
        speed_t codes[4];
        int     duties[4];
        int     hi_a;
        int     hi_b;
        int     i;
        codes  = '{SPEED_OFF, SPEED_LOW, SPEED_MID, SPEED_FULL};
        duties = '{0, int'(DUTY_LOW), int'(DUTY_MID), int'(DUTY_FULL)};
        apply_reset();
        check_bit(pwm_a, 1'b0, "pwm_a after reset");
        check_bit(pwm_b, 1'b0, "pwm_b after reset");
        check_bit(trigger, 1'b0, "trigger after reset");
        check_bit(obstacle, 1'b0, "obstacle after reset");
        check_bit(fault, 1'b0, "fault after reset");
        check_dir(motor_dir, '0, "motor_dir after reset");
        check_seg(seg, SEG_BLANK, "seg after reset"); // Scan starts on the blank digit
        for (i = 0; i < 4; i++) begin
            speed_a = codes[i];
            speed_b = codes[3 - i];
            repeat (3) next_cycle();
            count_pwm_high(hi_a, hi_b);
            check_count(hi_a, duties[i], 0, "pwm_a high cycles");
            check_count(hi_b, duties[3 - i], 0, "pwm_b high cycles");
        end
    endtask

    task automatic steering_rules();
        line = LINE_ALL; // First crossroads, spin into follow
        next_cycle();
        line = LINE_NONE;
        repeat (TURN_CYCLES + 4) next_cycle();
        steer_case(LINE_LEFT, EXP_SPIN_LEFT, "left only");
        steer_case(LINE_RIGHT, EXP_SPIN_RIGHT, "right only");
        steer_case(LINE_CENTER, EXP_FWD, "center only");
        steer_case(LINE_NONE, EXP_FWD, "no line");
        steer_case(LINE_LEFT_CENTER, EXP_FWD, "left and center");
        steer_case(LINE_ALL, EXP_FWD, "all on line in follow");
        steer_case(LINE_LEFT, EXP_SPIN_LEFT, "left only again");
    endtask

    task automatic crossroads_turn();
        int spin_len;
        line = LINE_NONE;
        apply_reset();
        repeat (2) next_cycle();
        check_dir(motor_dir, EXP_FWD, "straight before crossroads");
        line = LINE_ALL;
        next_cycle();
        check_dir(motor_dir, EXP_SPIN_LEFT, "spin start");
        line = LINE_NONE;
        spin_len = 1;
        next_cycle();
        while (motor_dir == EXP_SPIN_LEFT && spin_len <= TURN_CYCLES + 8) begin
            spin_len++;
            next_cycle();
        end
        check_count(spin_len, TURN_CYCLES, 2, "spin length");
        check_dir(motor_dir, EXP_FWD, "straight after spin");
        steer_case(LINE_RIGHT, EXP_SPIN_RIGHT, "right only after spin");
        steer_case(LINE_ALL, EXP_FWD, "second crossroads");
        repeat (8) next_cycle();
        check_dir(motor_dir, EXP_FWD, "no spin at second crossroads");
    endtask

    task automatic obstacle_stop();
        int width;
        int hi_a;
        int hi_b;
        speed_a = SPEED_FULL;
        speed_b = SPEED_FULL;
        check_bit(obstacle, 1'b0, "obstacle before near echo");
        width = 1 + int'($unsigned($random(seed)) % (NEAR_CYCLES - 1));
        send_echo(width);
        wait_obstacle(1'b1, "obstacle after near echo");
        repeat (2) next_cycle();
        repeat (64) begin
            check_bit(pwm_a, 1'b0, "pwm_a with obstacle");
            check_bit(pwm_b, 1'b0, "pwm_b with obstacle");
            next_cycle();
        end
        width = NEAR_CYCLES + 1 + int'($unsigned($random(seed)) % 400);
        send_echo(width);
        wait_obstacle(1'b0, "obstacle after far echo");
        repeat (2) next_cycle();
        count_pwm_high(hi_a, hi_b);
        check_count(hi_a, int'(DUTY_FULL), 0, "pwm_a high cycles after obstacle");
        check_count(hi_b, int'(DUTY_FULL), 0, "pwm_b high cycles after obstacle");
    endtask

    task automatic overcurrent_fault();
        logic [3:0] seen;
        oc_a = 1'b1;
        repeat (OC_HOLD_CYCLES) next_cycle();
        check_bit(fault, 1'b0, "fault while hold count builds"); // Latches one cycle later
        repeat (2) next_cycle();
        oc_a = 1'b0;
        check_bit(fault, 1'b1, "fault after overcurrent");
        repeat (2) next_cycle();
        seen = '0;
        repeat (SCAN_PERIOD) begin
            check_bit(pwm_a, 1'b0, "pwm_a during fault");
            check_bit(pwm_b, 1'b0, "pwm_b during fault");
            check_seg(seg, SEG_DASH, "digit during fault");
            seen = seen | ~an;
            next_cycle();
        end
        check_bit(&seen, 1'b1, "all anodes scanned during fault");
        clear_btn = 1'b1;
        next_cycle();
        clear_btn = 1'b0;
        check_bit(fault, 1'b0, "fault after clear");
        repeat (4) next_cycle();
        check_bit(fault, 1'b0, "fault stays clear");
    endtask

    task automatic temperature_readout();
        adc_sample = 12'd1925; // 620 above offset, reads 20
        adc_valid  = 1'b1;
        next_cycle();
        adc_valid  = 1'b0;
        scan_display(SEG_2, SEG_0, "sample 1925");
        adc_sample = 12'd1000; // Below the offset
        adc_valid  = 1'b1;
        next_cycle();
        adc_valid  = 1'b0;
        scan_display(SEG_0, SEG_0, "sample 1000");
    endtask

    // Pulse width and repeat period, measured from one rising edge to the next
    task automatic trigger_timing();
        int high_len;
        int period_len;
        int guard;
        guard = 0;
        while (trigger !== 1'b0 && guard < TRIG_PERIOD) begin
            next_cycle();
            guard++;
        end
        while (trigger !== 1'b1 && guard < 2 * TRIG_PERIOD) begin
            next_cycle();
            guard++;
        end
        check_bit(trigger, 1'b1, "trigger rising edge");
        high_len   = 0;
        period_len = 0;
        while (trigger === 1'b1 && period_len < TRIG_PERIOD) begin
            high_len++;
            period_len++;
            next_cycle();
        end
        while (trigger === 1'b0 && period_len < TRIG_PERIOD + 4) begin
            period_len++;
            next_cycle();
        end
        check_count(high_len, TRIG_CYCLES, 0, "trigger high cycles");
        check_count(period_len, TRIG_PERIOD, 0, "trigger period");
    endtask

    initial begin
        rst        = 1'b1;
        speed_a    = SPEED_OFF;
        speed_b    = SPEED_OFF;
        oc_a       = 1'b0;
        oc_b       = 1'b0;
        clear_btn  = 1'b0;
        line       = LINE_NONE;
        echo       = 1'b0;
        adc_sample = '0;
        adc_valid  = 1'b0;

        reset_and_speed();
        steering_rules();
        crossroads_turn();
        obstacle_stop();
        overcurrent_fault();
        temperature_readout();
        trigger_timing();

        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
